/* rtl/coreplex_macros.svh */
// Memory map and width constants of the coreplex fabric.
// Include this header wherever a base, a mask or a bus width is needed.
`ifndef COREPLEX_MACROS_SVH
`define COREPLEX_MACROS_SVH

// Bus widths
`define CF_XLEN        32                      // Address and data width
`define CF_BE_WIDTH    (`CF_XLEN / 8)          // One enable per byte

// TCM window
`define CF_TCM_AWIDTH  12                      // Byte-address bits inside the TCM
`define CF_TCM_DEPTH   (1 << (`CF_TCM_AWIDTH - 2))
`define CF_TCM_BASE    32'h8000_0000
`define CF_TCM_MASK    ((32'h1 << `CF_TCM_AWIDTH) - 32'h1)

// Peripheral data window
`define CF_PD_BASE     32'h1000_0000
`define CF_PD_MASK     32'h0fff_ffff

`endif

/* rtl/bus_pkg.sv */
// Vector types shared by the CPU-side ports and the peripheral bus.
// Referenced by scoped name, e.g. bus_pkg::addr_t.
package bus_pkg;

`include "coreplex_macros.svh"

    // Byte address, both CPU ports and peripheral command
    typedef logic [`CF_XLEN-1:0]      addr_t;

    // Read and write data word
    typedef logic [`CF_XLEN-1:0]      data_t;

    // Byte enables, also used as peripheral write mask
    typedef logic [`CF_BE_WIDTH-1:0]  be_t;

    // Word index into the TCM array
    typedef logic [`CF_TCM_AWIDTH-3:0] tcm_idx_t;

endpackage

/* rtl/map_pkg.sv */
// Memory map types: where a request goes and how a window is described.
// The window check is shared by the decoder and the bridge assertion.
package map_pkg;

`include "coreplex_macros.svh"

    // Decode result of one CPU port
    typedef enum logic [1:0] {
        TGT_NONE   = 2'd0,   // Unmapped, never granted
        TGT_TCM    = 2'd1,
        TGT_PERIPH = 2'd2
    } target_e;

    typedef logic [`CF_XLEN-1:0] window_t;  // Base or mask

    // Address hits the window when all bits above the mask match the base
    function automatic logic in_window(window_t addr, window_t base, window_t mask);
        return (addr & ~mask) == (base & ~mask);
    endfunction

endpackage

/* rtl/mem_port_if.sv */
// One decoded CPU request towards a single target, plus its reply.
// The decoder takes the initiator side, the TCM or bridge the target side.
`timescale 1ns/1ps

interface mem_port_if;

    // Request, driven by the decoder
    logic            cs;      // Address falls in this target's window
    logic            we;
    bus_pkg::be_t    be;
    bus_pkg::addr_t  addr;
    bus_pkg::data_t  wdata;

    // Reply, driven by the target
    logic            gnt;     // Accepted when cs && gnt
    logic            rvalid;  // One pulse per accepted request
    bus_pkg::data_t  rdata;   // Zero for writes

    modport initiator (
        output cs, we, be, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport target (
        input  cs, we, be, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

/* rtl/fabric_decoder.sv */
// Address decoder and reply merger for the instruction and data CPU ports.
// Instruction fetches reach the TCM only; data goes to TCM or peripheral bus.
// Unmapped requests select no target and therefore never get a grant.
`timescale 1ns/1ps
`include "coreplex_macros.svh"

module fabric_decoder (
    input  logic                clk,
    input  logic                rst_n,
    // Instruction port
    input  logic                instr_req_i,
    input  bus_pkg::addr_t      instr_addr_i,
    output logic                instr_gnt_o,
    output logic                instr_rvalid_o,
    output bus_pkg::data_t      instr_rdata_o,
    // Data port
    input  logic                data_req_i,
    input  logic                data_we_i,
    input  bus_pkg::be_t        data_be_i,
    input  bus_pkg::addr_t      data_addr_i,
    input  bus_pkg::data_t      data_wdata_i,
    output logic                data_gnt_o,
    output logic                data_rvalid_o,
    output bus_pkg::data_t      data_rdata_o,
    output logic                data_err_o,
    // Targets
    mem_port_if.initiator       tcm_i_port,
    mem_port_if.initiator       tcm_d_port,
    mem_port_if.initiator       pd_port
);

    localparam map_pkg::window_t TCM_BASE = `CF_TCM_BASE;
    localparam map_pkg::window_t TCM_MASK = `CF_TCM_MASK;
    localparam map_pkg::window_t PD_BASE  = `CF_PD_BASE;
    localparam map_pkg::window_t PD_MASK  = `CF_PD_MASK;

    map_pkg::target_e instr_tgt;
    map_pkg::target_e data_tgt;
    logic [3:0]       data_pend_q;   // Data responses still owed to the CPU

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    always_comb begin
        instr_tgt = map_pkg::TGT_NONE;
        if (instr_req_i && map_pkg::in_window(instr_addr_i, TCM_BASE, TCM_MASK)) begin
            instr_tgt = map_pkg::TGT_TCM;
        end

        data_tgt = map_pkg::TGT_NONE;
        if (data_req_i) begin
            if (map_pkg::in_window(data_addr_i, TCM_BASE, TCM_MASK))
                data_tgt = map_pkg::TGT_TCM;
            else if (map_pkg::in_window(data_addr_i, PD_BASE, PD_MASK))
                data_tgt = map_pkg::TGT_PERIPH;
        end
    end

    // Fetches are full-word reads on TCM port A
    assign tcm_i_port.cs    = (instr_tgt == map_pkg::TGT_TCM);
    assign tcm_i_port.we    = 1'b0;
    assign tcm_i_port.be    = '1;
    assign tcm_i_port.addr  = instr_addr_i;
    assign tcm_i_port.wdata = '0;

    // Data fields fan out, only cs differs
    assign tcm_d_port.cs    = (data_tgt == map_pkg::TGT_TCM);
    assign tcm_d_port.we    = data_we_i;
    assign tcm_d_port.be    = data_be_i;
    assign tcm_d_port.addr  = data_addr_i;
    assign tcm_d_port.wdata = data_wdata_i;

    assign pd_port.cs       = (data_tgt == map_pkg::TGT_PERIPH);
    assign pd_port.we       = data_we_i;
    assign pd_port.be       = data_be_i;
    assign pd_port.addr     = data_addr_i;
    assign pd_port.wdata    = data_wdata_i;

    // ------------------------------------------------------------
    // Reply merge
    // ------------------------------------------------------------
    assign instr_gnt_o    = tcm_i_port.gnt;
    assign instr_rvalid_o = tcm_i_port.rvalid;
    assign instr_rdata_o  = tcm_i_port.rdata & {`CF_XLEN{tcm_i_port.rvalid}};

    always_comb begin
        case (data_tgt)
            map_pkg::TGT_TCM:    data_gnt_o = tcm_d_port.gnt;
            map_pkg::TGT_PERIPH: data_gnt_o = pd_port.gnt;
            default:             data_gnt_o = 1'b0;   // Unmapped stalls
        endcase
    end

    // Peripheral and TCM replies may land in different cycles than issued
    assign data_rvalid_o = tcm_d_port.rvalid | pd_port.rvalid;
    assign data_rdata_o  = (tcm_d_port.rdata & {`CF_XLEN{tcm_d_port.rvalid}}) |
                           (pd_port.rdata    & {`CF_XLEN{pd_port.rvalid}});
    assign data_err_o    = 1'b0;   // No target reports errors

    // Outstanding data accesses, grant adds one, rvalid retires one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_pend_q <= '0;
        end else begin
            data_pend_q <= data_pend_q + {3'b0, data_gnt_o} - {3'b0, data_rvalid_o};
        end
    end

    // At most one data reply per cycle since the merge is a plain OR
    a_one_data_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({tcm_d_port.rvalid, pd_port.rvalid}));

    // No target answers a data access that was never granted
    a_no_orphan_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        data_rvalid_o |-> (data_pend_q != '0));

endmodule

/* rtl/tcm_ram.sv */
// Dual-port tightly coupled memory, 1024 words.
// Port A serves instruction fetches, port B data reads and byte writes.
// Both ports grant at once and return rvalid one cycle after cs.
`timescale 1ns/1ps
`include "coreplex_macros.svh"

module tcm_ram (
    input  logic       clk,
    input  logic       rst_n,
    mem_port_if.target tcm_i_port,   // Port A, read only
    mem_port_if.target tcm_d_port    // Port B, read and write
);

    bus_pkg::data_t   mem [`CF_TCM_DEPTH];
    bus_pkg::tcm_idx_t idx_a;
    bus_pkg::tcm_idx_t idx_b;
    bus_pkg::data_t   rdata_a_q;
    bus_pkg::data_t   rdata_b_q;
    logic             rvalid_a_q;
    logic             rvalid_b_q;
    logic             wr_b_q;        // Port B reply belongs to a write

    initial begin
        for (int i = 0; i < `CF_TCM_DEPTH; i++)
            mem[i] = '0;
    end

    assign idx_a = tcm_i_port.addr[`CF_TCM_AWIDTH-1:2];   // Word index
    assign idx_b = tcm_d_port.addr[`CF_TCM_AWIDTH-1:2];

    // No back-pressure
    assign tcm_i_port.gnt = tcm_i_port.cs;
    assign tcm_d_port.gnt = tcm_d_port.cs;

    // Byte writes through port B
    always @(posedge clk) begin
        if (tcm_d_port.cs && tcm_d_port.we) begin
            for (int b = 0; b < `CF_BE_WIDTH; b++) begin
                if (tcm_d_port.be[b])
                    mem[idx_b][b*8 +: 8] <= tcm_d_port.wdata[b*8 +: 8];
            end
        end
    end

    // Read data, old word on a write
    always_ff @(posedge clk) begin
        if (tcm_i_port.cs) rdata_a_q <= mem[idx_a];
        if (tcm_d_port.cs) rdata_b_q <= mem[idx_b];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_a_q <= 1'b0;
            rvalid_b_q <= 1'b0;
            wr_b_q     <= 1'b0;
        end else begin
            rvalid_a_q <= tcm_i_port.cs;
            rvalid_b_q <= tcm_d_port.cs;
            wr_b_q     <= tcm_d_port.cs & tcm_d_port.we;
        end
    end

    assign tcm_i_port.rvalid = rvalid_a_q;
    assign tcm_i_port.rdata  = rdata_a_q;
    assign tcm_d_port.rvalid = rvalid_b_q;
    assign tcm_d_port.rdata  = wr_b_q ? '0 : rdata_b_q;   // Writes reply with zero

    // Fetch side must never issue a write
    a_port_a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        tcm_i_port.cs |-> !tcm_i_port.we);

endmodule

/* rtl/icb_bridge.sv */
// Bridge from decoded data requests to the peripheral command/response bus.
// A command is offered while cs is high and granted when the bus is ready.
// Responses are always accepted and returned one cycle later.
`timescale 1ns/1ps
`include "coreplex_macros.svh"

module icb_bridge (
    input  logic            clk,
    input  logic            rst_n,
    mem_port_if.target      pd_port,
    // Peripheral command channel
    output logic            pd_cmd_valid_o,
    input  logic            pd_cmd_ready_i,
    output logic            pd_cmd_read_o,
    output bus_pkg::addr_t  pd_cmd_addr_o,
    output bus_pkg::data_t  pd_cmd_wdata_o,
    output bus_pkg::be_t    pd_cmd_wmask_o,
    // Peripheral response channel
    input  logic            pd_rsp_valid_i,
    output logic            pd_rsp_ready_o,
    input  bus_pkg::data_t  pd_rsp_rdata_i
);

    logic           rsp_take;     // Response accepted this cycle
    logic           rvalid_q;
    bus_pkg::data_t rdata_q;

    // ------------------------------------------------------------
    // Command side
    // ------------------------------------------------------------
    assign pd_cmd_valid_o = pd_port.cs;
    assign pd_cmd_read_o  = ~pd_port.we;
    assign pd_cmd_addr_o  = pd_port.addr;
    assign pd_cmd_wdata_o = pd_port.wdata;
    assign pd_cmd_wmask_o = pd_port.be;
    assign pd_port.gnt    = pd_port.cs & pd_cmd_ready_i;   // Held until ready

    // ------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------
    assign pd_rsp_ready_o = 1'b1;
    assign rsp_take       = pd_rsp_valid_i & pd_rsp_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rsp_take;
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= rsp_take ? pd_rsp_rdata_i : '0;   // Zero when idle
    end

    assign pd_port.rvalid = rvalid_q;
    assign pd_port.rdata  = rdata_q;

    // Decoder must keep foreign addresses off the bus
    a_cmd_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        pd_cmd_valid_o |-> map_pkg::in_window(pd_cmd_addr_o, `CF_PD_BASE, `CF_PD_MASK));

endmodule

/* rtl/coreplex_fabric.sv */
// Top level of the memory-side fabric: CPU instruction and data ports in,
// TCM inside, peripheral data bus out. Instances and wiring only.
`timescale 1ns/1ps

module coreplex_fabric (
    input  logic            clk,
    input  logic            rst_n,
    // Instruction port
    input  logic            instr_req_i,
    input  bus_pkg::addr_t  instr_addr_i,
    output logic            instr_gnt_o,
    output logic            instr_rvalid_o,
    output bus_pkg::data_t  instr_rdata_o,
    // Data port
    input  logic            data_req_i,
    input  logic            data_we_i,
    input  bus_pkg::be_t    data_be_i,
    input  bus_pkg::addr_t  data_addr_i,
    input  bus_pkg::data_t  data_wdata_i,
    output logic            data_gnt_o,
    output logic            data_rvalid_o,
    output bus_pkg::data_t  data_rdata_o,
    output logic            data_err_o,
    // Peripheral data bus
    output logic            pd_cmd_valid_o,
    input  logic            pd_cmd_ready_i,
    output logic            pd_cmd_read_o,
    output bus_pkg::addr_t  pd_cmd_addr_o,
    output bus_pkg::data_t  pd_cmd_wdata_o,
    output bus_pkg::be_t    pd_cmd_wmask_o,
    input  logic            pd_rsp_valid_i,
    output logic            pd_rsp_ready_o,
    input  bus_pkg::data_t  pd_rsp_rdata_i
);

    mem_port_if tcm_i_port ();   // Fetch to TCM port A
    mem_port_if tcm_d_port ();   // Data to TCM port B
    mem_port_if pd_port ();      // Data to peripheral bridge

    fabric_decoder u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .data_err_o     (data_err_o),
        .tcm_i_port     (tcm_i_port.initiator),
        .tcm_d_port     (tcm_d_port.initiator),
        .pd_port        (pd_port.initiator)
    );

    tcm_ram u_tcm (
        .clk        (clk),
        .rst_n      (rst_n),
        .tcm_i_port (tcm_i_port.target),
        .tcm_d_port (tcm_d_port.target)
    );

    icb_bridge u_pd_bridge (
        .clk            (clk),
        .rst_n          (rst_n),
        .pd_port        (pd_port.target),
        .pd_cmd_valid_o (pd_cmd_valid_o),
        .pd_cmd_ready_i (pd_cmd_ready_i),
        .pd_cmd_read_o  (pd_cmd_read_o),
        .pd_cmd_addr_o  (pd_cmd_addr_o),
        .pd_cmd_wdata_o (pd_cmd_wdata_o),
        .pd_cmd_wmask_o (pd_cmd_wmask_o),
        .pd_rsp_valid_i (pd_rsp_valid_i),
        .pd_rsp_ready_o (pd_rsp_ready_o),
        .pd_rsp_rdata_i (pd_rsp_rdata_i)
    );

endmodule

/* verification/tb_coreplex_fabric.sv */
// Testbench for the coreplex fabric. Replays the transactions of the stimulus
// file on the fetch and data ports, models the peripheral slave and checks
// every reply against a reference TCM and the slave's XOR rule.
`timescale 1ns/1ps
`include "coreplex_macros.svh"

module tb_coreplex_fabric;

    logic           clk         = 1'b0;
    logic           rst_n       = 1'b0;
    logic           instr_req   = 1'b0;
    bus_pkg::addr_t instr_addr  = '0;
    logic           data_req    = 1'b0;
    logic           data_we     = 1'b0;
    bus_pkg::be_t   data_be     = '0;
    bus_pkg::addr_t data_addr   = '0;
    bus_pkg::data_t data_wdata  = '0;
    logic           instr_gnt;
    logic           instr_rvalid;
    bus_pkg::data_t instr_rdata;
    logic           data_gnt;
    logic           data_rvalid;
    bus_pkg::data_t data_rdata;
    logic           data_err;
    logic           pd_cmd_valid;
    logic           pd_cmd_read;
    bus_pkg::addr_t pd_cmd_addr;
    bus_pkg::data_t pd_cmd_wdata;
    bus_pkg::be_t   pd_cmd_wmask;
    logic           pd_rsp_ready;

    // Slave side, owned by the peripheral model
    logic           pd_cmd_ready = 1'b0;
    logic           pd_rsp_valid = 1'b0;
    bus_pkg::data_t pd_rsp_rdata = '0;
    logic           fire_seen    = 1'b0;   // Command transferred this cycle
    logic           fire_read    = 1'b0;
    bus_pkg::addr_t fire_addr    = '0;
    logic [31:0]    ready_rnd;

    int unsigned    errors       = 0;
    int unsigned    tests        = 0;
    bus_pkg::data_t shadow [`CF_TCM_DEPTH];   // Reference TCM contents

    always #20 clk = ~clk;   // 40 ns period

    coreplex_fabric uut (
        .clk(clk), .rst_n(rst_n),
        .instr_req_i(instr_req), .instr_addr_i(instr_addr),
        .instr_gnt_o(instr_gnt), .instr_rvalid_o(instr_rvalid), .instr_rdata_o(instr_rdata),
        .data_req_i(data_req), .data_we_i(data_we), .data_be_i(data_be),
        .data_addr_i(data_addr), .data_wdata_i(data_wdata),
        .data_gnt_o(data_gnt), .data_rvalid_o(data_rvalid), .data_rdata_o(data_rdata),
        .data_err_o(data_err),
        .pd_cmd_valid_o(pd_cmd_valid), .pd_cmd_ready_i(pd_cmd_ready),
        .pd_cmd_read_o(pd_cmd_read), .pd_cmd_addr_o(pd_cmd_addr),
        .pd_cmd_wdata_o(pd_cmd_wdata), .pd_cmd_wmask_o(pd_cmd_wmask),
        .pd_rsp_valid_i(pd_rsp_valid), .pd_rsp_ready_o(pd_rsp_ready),
        .pd_rsp_rdata_i(pd_rsp_rdata)
    );

    // ------------------------------------------------------------
    // Peripheral slave
    // ------------------------------------------------------------
    always @(negedge clk) begin
        fire_seen = pd_cmd_valid && pd_cmd_ready;   // Sampled mid-cycle
        fire_read = pd_cmd_read;
        fire_addr = pd_cmd_addr;
    end

    always @(posedge clk) begin
        ready_rnd = $urandom;
        pd_cmd_ready <= ready_rnd[0];               // Ready on random cycles
        pd_rsp_valid <= fire_seen;                  // Answer one cycle later
        pd_rsp_rdata <= (fire_seen && fire_read) ? (fire_addr ^ 32'h5a5a_5a5a) : '0;
    end

    // ------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------
    // 0 unmapped, 1 TCM, 2 peripheral; fetches see only the TCM
    function automatic int window_of(input bus_pkg::addr_t addr, input logic fetch);
        if ((addr & ~`CF_TCM_MASK) == `CF_TCM_BASE)
            return 1;
        if (!fetch && ((addr & ~`CF_PD_MASK) == `CF_PD_BASE))
            return 2;
        return 0;
    endfunction

    function automatic string window_name(input int kind);
        if (kind == 1)
            return "tcm";
        if (kind == 2)
            return "periph";
        return "unmapped";
    endfunction

    // Byte-enable merge of a write into the old word
    function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old_word,
            input bus_pkg::data_t new_word, input bus_pkg::be_t be);
        bus_pkg::data_t res;
        int             b;
        res = old_word;
        for (b = 0; b < 4; b++) begin
            if (be[b])
                res[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return res;
    endfunction

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic check_reset_state();
        tests++;
        @(negedge clk);
        assert (!instr_gnt && !instr_rvalid && !data_gnt && !data_rvalid && !data_err
                && !pd_cmd_valid && instr_rdata == '0 && data_rdata == '0)
        else begin
            $display("FAILED at %0t: outputs not idle after reset", $time);
            errors++;
        end
        $display("Test %0d: reset state, %s", tests, (errors == 0) ? "ok" : "error");
    endtask

    // Command on the bus mirrors the request, grant only with ready
    task automatic check_pd_cmd(input logic we, input bus_pkg::addr_t addr,
            input bus_pkg::data_t wdata, input bus_pkg::be_t be, input logic gnt);
        assert (pd_cmd_valid && pd_cmd_addr == addr && pd_cmd_read == !we
                && pd_cmd_wdata == wdata && pd_cmd_wmask == be)
        else begin
            $display("FAILED at %0t: peripheral command differs from request %h", $time, addr);
            errors++;
        end
        assert (gnt == pd_cmd_ready) else begin
            $display("FAILED at %0t: grant %0b with ready %0b", $time, gnt, pd_cmd_ready);
            errors++;
        end
        assert (pd_rsp_ready) else begin   // Responses always accepted
            $display("FAILED at %0t: response ready is %0b", $time, pd_rsp_ready);
            errors++;
        end
    endtask

    task automatic run_txn(input byte op, input bus_pkg::addr_t addr,
            input bus_pkg::data_t wdata, input bus_pkg::be_t be,
            input bus_pkg::data_t file_exp);
        int             kind;
        int             limit;
        int             cycles;
        int unsigned    err_before;
        logic           fetch;
        logic           we;
        logic           granted;
        logic           got_rv;
        bus_pkg::data_t exp_rdata;
        bus_pkg::data_t rdata;

        fetch      = (op == "I");
        we         = (op == "W");
        kind       = window_of(addr, fetch);
        limit      = (kind == 0) ? 20 : 200;   // Unmapped gets 20 cycles
        err_before = errors;
        tests++;

        if (we)
            exp_rdata = '0;
        else if (kind == 1)
            exp_rdata = shadow[addr[`CF_TCM_AWIDTH-1:2]];
        else
            exp_rdata = addr ^ 32'h5a5a_5a5a;
        if (kind != 0) begin
            assert (exp_rdata == file_exp) else begin
                $display("FAILED at %0t: file expects %h at %h, rules give %h",
                         $time, file_exp, addr, exp_rdata);
                errors++;
            end
        end

        @(posedge clk);
        if (fetch) begin
            instr_req  <= 1'b1;
            instr_addr <= addr;
        end else begin
            data_req   <= 1'b1;
            data_we    <= we;
            data_be    <= be;
            data_addr  <= addr;
            data_wdata <= wdata;
        end

        // Hold until granted
        granted = 1'b0;
        cycles  = 0;
        while (!granted && cycles < limit) begin
            @(negedge clk);
            granted = fetch ? instr_gnt : data_gnt;
            if (kind == 2)
                check_pd_cmd(we, addr, wdata, be, granted);
            @(posedge clk);                    // Acceptance edge
            cycles++;
        end
        instr_req <= 1'b0;
        data_req  <= 1'b0;

        if (kind == 0) begin
            assert (!granted) else begin
                $display("FAILED at %0t: unmapped address %h was granted", $time, addr);
                errors++;
            end
        end else begin
            assert (granted) else begin
                $display("Timeout: request to %h not granted in %0d cycles", addr, limit);
                errors++;
            end
        end

        if (granted && kind != 0) begin
            assert (kind != 1 || cycles == 1) else begin
                $display("FAILED at %0t: TCM grant took %0d cycles", $time, cycles);
                errors++;
            end
            if (kind == 1 && we)
                shadow[addr[`CF_TCM_AWIDTH-1:2]] =
                    merge_bytes(shadow[addr[`CF_TCM_AWIDTH-1:2]], wdata, be);

            got_rv = 1'b0;
            rdata  = '0;
            cycles = 0;
            while (!got_rv && cycles < 100) begin
                @(negedge clk);
                cycles++;
                got_rv = fetch ? instr_rvalid : data_rvalid;
                rdata  = fetch ? instr_rdata : data_rdata;
            end
            assert (got_rv) else begin
                $display("Timeout: no rvalid for %c at %h in 100 cycles", op, addr);
                errors++;
            end
            if (got_rv) begin
                // Slave answers one cycle after the command, bridge adds one more
                assert (cycles == ((kind == 2) ? 2 : 1)) else begin
                    $display("FAILED at %0t: rvalid %0d cycles after grant", $time, cycles);
                    errors++;
                end
                assert (rdata == exp_rdata) else begin
                    $display("FAILED at %0t: %c %h returned %h, expected %h",
                             $time, op, addr, rdata, exp_rdata);
                    errors++;
                end
            end
        end

        $display("Test %0d: %c %h %s, %s", tests, op, addr, window_name(kind),
                 (errors == err_before) ? "ok" : "error");
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int             fd;
        int             n;
        int             i;
        string          line;
        byte            op;
        bus_pkg::addr_t f_addr;
        bus_pkg::data_t f_wdata;
        bus_pkg::be_t   f_be;
        bus_pkg::data_t f_exp;

        void'($urandom(32'hfb529ee0));
        for (i = 0; i < `CF_TCM_DEPTH; i++)
            shadow[i] = '0;                    // TCM starts cleared

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();

        fd = $fopen("verification/fabric_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h", op, f_addr, f_wdata, f_be, f_exp);
                    if (n == 5) begin
                        run_txn(op, f_addr, f_wdata, f_be, f_exp);
                    end else begin
                        $display("Malformed stimulus line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* coreplex_fabric.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/map_pkg.sv
rtl/mem_port_if.sv
rtl/fabric_decoder.sv
rtl/tcm_ram.sv
rtl/icb_bridge.sv
rtl/coreplex_fabric.sv
verification/tb_coreplex_fabric.sv

/* Makefile */
# Verilator build and run of the coreplex fabric testbench

sim:
	verilator --binary --timing --assert -f coreplex_fabric.f --top-module tb_coreplex_fabric -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "Run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* verification/fabric_stimulus.txt */
# op addr wdata be expected_rdata, all hex; op I fetch, R data read, W data write
# Writes expect zero; unmapped lines expect zero and must never be granted
W 80000000 11223344 f 00000000
W 80000004 aabbccdd f 00000000
W 80000004 000000ee 1 00000000
W 80000004 55660000 c 00000000
R 80000004 00000000 f 5566ccee
W 80000008 deadbeef 6 00000000
R 80000008 00000000 f 00adbe00
W 80000ffc 12345678 9 00000000
R 80000ffc 00000000 f 12000078
R 80000000 00000000 f 11223344
I 80000000 00000000 f 11223344
I 80000004 00000000 f 5566ccee
I 80000008 00000000 f 00adbe00
I 80000ffc 00000000 f 12000078
I 80000100 00000000 f 00000000
W 80000100 cafef00d 3 00000000
I 80000100 00000000 f 0000f00d
R 10000000 00000000 f 4a5a5a5a
R 10000004 00000000 f 4a5a5a5e
R 1abc0010 00000000 f 40e65a4a
W 10000008 0badf00d f 00000000
W 1ffffffc 01020304 5 00000000
R 1ffffffc 00000000 f 45a5a5a6
R 10001230 00000000 f 4a5a486a
W 10000010 ffffffff 2 00000000
R 40000000 00000000 f 00000000
W 00000000 01010101 f 00000000
R 80001000 00000000 f 00000000
R 20000000 00000000 f 00000000
I 10000000 00000000 f 00000000
